//--- mem_pkg.sv
package mem_pkg;

    // lane logic assumes four byte lanes
    localparam int DATA_W     = 32;
    localparam int SEL_W      = 4;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [3:0] {
        NONE,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWL,
        LWR,
        SB,
        SH,
        SW,
        SWL,
        SWR
    } mem_op_e;

    // big-endian lanes, b[3] and h[1] sit at byte offset 0
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage

//--- mem_req_stage.sv
`timescale 1ns/1ps

module mem_req_stage #(
    parameter int ADDR_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            valid_i,
    input  mem_pkg::mem_op_e                op_i,
    input  logic [ADDR_W-1:0]               addr_i,
    input  logic [mem_pkg::DATA_W-1:0]      reg2_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0]  wd_i,
    input  logic                            wreg_i,

    output logic                            mem_ce_o,
    output logic                            mem_we_o,
    output logic [mem_pkg::SEL_W-1:0]       mem_sel_o,
    output logic [ADDR_W-1:0]               mem_addr_o,
    output logic [mem_pkg::DATA_W-1:0]      mem_data_o,

    output logic                            s2_valid_o,
    output mem_pkg::mem_op_e                s2_op_o,
    output logic [1:0]                      s2_offset_o,
    output logic [mem_pkg::DATA_W-1:0]      s2_reg2_o,
    output logic [mem_pkg::REG_ADDR_W-1:0]  s2_wd_o,
    output logic                            s2_wreg_o,
    output logic                            s2_noaccess_o
);
    import mem_pkg::*;

    logic [1:0]        offset;
    logic              is_store;
    logic              word_op;
    logic              noaccess;
    logic              ce_d;
    logic [SEL_W-1:0]  sel_d;
    logic [ADDR_W-1:0] addr_d;
    mem_word_u         src_w;
    mem_word_u         store_w;

    assign offset = addr_i[1:0];
    assign src_w  = reg2_i;

    // odd halfword never reaches the RAM
    assign noaccess = (op_i inside {LH, LHU, SH}) && offset[0];
    assign ce_d     = valid_i && (op_i != NONE) && !noaccess;
    assign addr_d   = word_op ? {addr_i[ADDR_W-1:2], 2'b00} : addr_i;

    // lane select and store data
    always_comb begin
        sel_d    = '0;
        store_w  = '0;
        is_store = 1'b0;
        word_op  = 1'b0;
        case (op_i)
            LB, LBU: begin
                sel_d = 4'b1000 >> offset;
            end
            LH, LHU: begin
                sel_d = 4'b1100 >> offset;
            end
            LW, LWL, LWR: begin
                sel_d   = 4'b1111;
                word_op = 1'b1;
            end
            SB: begin
                is_store = 1'b1;
                sel_d    = 4'b1000 >> offset;
                for (int i = 0; i < SEL_W; i++) begin
                    store_w.b[i] = src_w.b[0];
                end
            end
            SH: begin
                is_store     = 1'b1;
                sel_d        = 4'b1100 >> offset;
                store_w.h[1] = src_w.h[0];
                store_w.h[0] = src_w.h[0];
            end
            SW: begin
                is_store = 1'b1;
                word_op  = 1'b1;
                sel_d    = 4'b1111;
                store_w  = src_w;
            end
            SWL: begin
                is_store = 1'b1;
                word_op  = 1'b1;
                // lowest 4-k lanes
                sel_d    = 4'b1111 >> offset;
                store_w  = reg2_i >> {offset, 3'b000};
            end
            SWR: begin
                is_store = 1'b1;
                word_op  = 1'b1;
                // highest k+1 lanes
                sel_d    = 4'b1111 << ~offset;
                store_w  = reg2_i << {~offset, 3'b000};
            end
            default: begin
                sel_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_ce_o      <= 1'b0;
            mem_we_o      <= 1'b0;
            mem_sel_o     <= '0;
            s2_valid_o    <= 1'b0;
            s2_op_o       <= NONE;
            s2_wreg_o     <= 1'b0;
            s2_noaccess_o <= 1'b0;
        end else begin
            mem_ce_o      <= ce_d;
            mem_we_o      <= ce_d && is_store;
            mem_sel_o     <= ce_d ? sel_d : '0;
            s2_valid_o    <= valid_i;
            s2_op_o       <= valid_i ? op_i : NONE;
            s2_wreg_o     <= valid_i && wreg_i;
            s2_noaccess_o <= valid_i && noaccess;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr_o  <= addr_d;
        mem_data_o  <= store_w;
        s2_offset_o <= offset;
        s2_reg2_o   <= reg2_i;
        s2_wd_o     <= wd_i;
    end

endmodule

//--- mem_load_align.sv
`timescale 1ns/1ps

module mem_load_align (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            s2_valid_i,
    input  mem_pkg::mem_op_e                s2_op_i,
    input  logic [1:0]                      s2_offset_i,
    input  logic [mem_pkg::DATA_W-1:0]      s2_reg2_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0]  s2_wd_i,
    input  logic                            s2_wreg_i,
    input  logic                            s2_noaccess_i,

    input  logic [mem_pkg::DATA_W-1:0]      mem_data_i,

    output logic                            wb_valid_o,
    output logic                            wb_wreg_o,
    output logic [mem_pkg::REG_ADDR_W-1:0]  wb_wd_o,
    output logic [mem_pkg::DATA_W-1:0]      wb_wdata_o
);
    import mem_pkg::*;

    // context held while the RAM read is in progress
    logic                  s3_valid;
    mem_op_e               s3_op;
    logic [1:0]            s3_offset;
    logic [DATA_W-1:0]     s3_reg2;
    logic [REG_ADDR_W-1:0] s3_wd;
    logic                  s3_wreg;
    logic                  s3_noaccess;

    mem_word_u             rd_w;
    logic [7:0]            byte_sel;
    logic [15:0]           half_sel;
    logic [4:0]            lo_shift;
    logic [4:0]            hi_shift;
    logic [DATA_W-1:0]     wdata_d;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s3_valid    <= 1'b0;
            s3_op       <= NONE;
            s3_wreg     <= 1'b0;
            s3_noaccess <= 1'b0;
        end else begin
            s3_valid    <= s2_valid_i;
            s3_op       <= s2_op_i;
            s3_wreg     <= s2_wreg_i;
            s3_noaccess <= s2_noaccess_i;
        end
    end

    always_ff @(posedge clk) begin
        s3_offset <= s2_offset_i;
        s3_reg2   <= s2_reg2_i;
        s3_wd     <= s2_wd_i;
    end

    // offset k names byte lane 3-k
    assign rd_w     = mem_data_i;
    assign byte_sel = rd_w.b[~s3_offset];
    assign half_sel = rd_w.h[~s3_offset[1]];
    assign lo_shift = {s3_offset, 3'b000};
    assign hi_shift = {~s3_offset, 3'b000};

    always_comb begin
        case (s3_op)
            LB:  wdata_d = {{(DATA_W-8){byte_sel[7]}}, byte_sel};
            LBU: wdata_d = {{(DATA_W-8){1'b0}}, byte_sel};
            LH: begin
                if (s3_noaccess) begin
                    wdata_d = '0;
                end else begin
                    wdata_d = {{(DATA_W-16){half_sel[15]}}, half_sel};
                end
            end
            LHU: begin
                if (s3_noaccess) begin
                    wdata_d = '0;
                end else begin
                    wdata_d = {{(DATA_W-16){1'b0}}, half_sel};
                end
            end
            LW:  wdata_d = mem_data_i;
            // memory bytes from the offset fill the top, reg2 keeps the rest
            LWL: wdata_d = (mem_data_i << lo_shift)
                         | (s3_reg2 & ~({DATA_W{1'b1}} << lo_shift));
            LWR: wdata_d = (mem_data_i >> hi_shift)
                         | (s3_reg2 & ~({DATA_W{1'b1}} >> hi_shift));
            default: wdata_d = s3_reg2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_wreg_o  <= 1'b0;
        end else begin
            wb_valid_o <= s3_valid;
            wb_wreg_o  <= s3_wreg;
        end
    end

    always_ff @(posedge clk) begin
        wb_wd_o    <= s3_wd;
        wb_wdata_o <= wdata_d;
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int ADDR_W = 32
) (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            valid_i,
    input  mem_pkg::mem_op_e                op_i,
    input  logic [ADDR_W-1:0]               addr_i,
    input  logic [mem_pkg::DATA_W-1:0]      reg2_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0]  wd_i,
    input  logic                            wreg_i,

    output logic                            mem_ce_o,
    output logic                            mem_we_o,
    output logic [mem_pkg::SEL_W-1:0]       mem_sel_o,
    output logic [ADDR_W-1:0]               mem_addr_o,
    output logic [mem_pkg::DATA_W-1:0]      mem_data_o,
    input  logic [mem_pkg::DATA_W-1:0]      mem_data_i,

    output logic                            wb_valid_o,
    output logic                            wb_wreg_o,
    output logic [mem_pkg::REG_ADDR_W-1:0]  wb_wd_o,
    output logic [mem_pkg::DATA_W-1:0]      wb_wdata_o
);
    import mem_pkg::*;

    logic                  s2_valid;
    mem_op_e               s2_op;
    logic [1:0]            s2_offset;
    logic [DATA_W-1:0]     s2_reg2;
    logic [REG_ADDR_W-1:0] s2_wd;
    logic                  s2_wreg;
    logic                  s2_noaccess;

    mem_req_stage #(
        .ADDR_W (ADDR_W)
    ) i_req (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .op_i          (op_i),
        .addr_i        (addr_i),
        .reg2_i        (reg2_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .mem_ce_o      (mem_ce_o),
        .mem_we_o      (mem_we_o),
        .mem_sel_o     (mem_sel_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_o    (mem_data_o),
        .s2_valid_o    (s2_valid),
        .s2_op_o       (s2_op),
        .s2_offset_o   (s2_offset),
        .s2_reg2_o     (s2_reg2),
        .s2_wd_o       (s2_wd),
        .s2_wreg_o     (s2_wreg),
        .s2_noaccess_o (s2_noaccess)
    );

    // read data arrives one cycle after the request
    mem_load_align i_align (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .s2_valid_i    (s2_valid),
        .s2_op_i       (s2_op),
        .s2_offset_i   (s2_offset),
        .s2_reg2_i     (s2_reg2),
        .s2_wd_i       (s2_wd),
        .s2_wreg_i     (s2_wreg),
        .s2_noaccess_i (s2_noaccess),
        .mem_data_i    (mem_data_i),
        .wb_valid_o    (wb_valid_o),
        .wb_wreg_o     (wb_wreg_o),
        .wb_wd_o       (wb_wd_o),
        .wb_wdata_o    (wb_wdata_o)
    );

endmodule

//--- tb_data_ram.sv
`timescale 1ns/1ps

module tb_data_ram #(
    parameter int ADDR_W = 10,
    parameter int DEPTH  = 256
) (
    input  logic              clk,
    input  logic              ce_i,
    input  logic              we_i,
    input  logic [3:0]        sel_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [31:0]       data_i,
    output logic [31:0]       data_o
);
    localparam int IDX_W = $clog2(DEPTH);

    logic [31:0]      mem [DEPTH];
    logic [IDX_W-1:0] idx;

    assign idx = addr_i[2 +: IDX_W];

    // read returns the old word
    always @(posedge clk) begin
        if (ce_i) begin
            data_o <= mem[idx];
            if (we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel_i[i]) begin
                        mem[idx][8*i +: 8] <= data_i[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- mem_stage_properties.sv
`timescale 1ns/1ps

module mem_stage_properties (
    input logic                      clk,
    input logic                      rst_n_i,
    input logic                      valid_i,
    input logic                      mem_ce_o,
    input logic                      mem_we_o,
    input logic [mem_pkg::SEL_W-1:0] mem_sel_o,
    input logic                      wb_valid_o,
    input logic                      wb_wreg_o
);

    a_we_needs_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_we_o |-> mem_ce_o)
        else $error("write strobe without chip enable");

    a_ce_needs_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_ce_o |-> (mem_sel_o != '0))
        else $error("chip enable with empty byte select");

    // request edge, align edge, writeback edge
    a_wb_follows_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o == $past(valid_i, 3))
        else $error("writeback valid out of step with accepted operations");

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |=> (!mem_ce_o && !mem_we_o && !wb_valid_o && !wb_wreg_o))
        else $error("outputs active during reset");

endmodule

bind mem_stage mem_stage_properties i_props (.*);

//--- tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_pkg::*;

    localparam int ADDR_W  = 10;
    localparam int N_RAND  = 400;
    localparam int N_PHASE = 5;
    localparam int N_DIR   = 172;
    localparam int LIMIT   = 2 * (N_DIR + N_PHASE * N_RAND) + 50;

    logic clk, rst_n_i, valid_i, wreg_i;
    mem_op_e op_i;
    logic [ADDR_W-1:0] addr_i, mem_addr_o;
    logic [31:0] reg2_i, mem_data_o, mem_data_i, wb_wdata_o;
    logic [4:0] wd_i, wb_wd_o;
    logic [3:0] mem_sel_o;
    logic mem_ce_o, mem_we_o, wb_valid_o, wb_wreg_o;

    logic [31:0] shadow [256];
    int q_due[$], q_valid[$], q_wreg[$], q_wd[$];
    logic [31:0] q_data[$];
    int errors, checks, cyc;
    logic chk_noce;

    mem_stage #(.ADDR_W(ADDR_W)) i_dut (.*);

    tb_data_ram #(.ADDR_W(ADDR_W), .DEPTH(256)) i_ram (
        .clk(clk), .ce_i(mem_ce_o), .we_i(mem_we_o), .sel_i(mem_sel_o),
        .addr_i(mem_addr_o), .data_i(mem_data_o), .data_o(mem_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc > LIMIT) begin
            $display("timeout: run went past %0d cycles without finishing", LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // byte p counts from the most significant end
    function automatic logic [7:0] byte_at(logic [31:0] w, int p);
        return w[31-8*p -: 8];
    endfunction

    function automatic logic [31:0] with_byte(logic [31:0] w, int p, logic [7:0] b);
        w[31-8*p -: 8] = b;
        return w;
    endfunction

    task automatic drive(input logic v, input mem_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [31:0] reg2);
        logic [31:0] w, res;
        logic [15:0] h;
        logic [7:0] b;
        int k, idx;
        @(posedge clk);
        #5;
        if (chk_noce) begin
            assert (!mem_ce_o) else begin
                errors++;
                $display("misaligned halfword reached the RAM");
            end
        end
        valid_i = v;
        op_i    = op;
        addr_i  = addr;
        reg2_i  = reg2;
        wd_i    = $urandom;
        wreg_i  = $urandom;
        idx = addr[ADDR_W-1:2];
        k   = addr[1:0];
        w   = shadow[idx];
        res = reg2;
        b   = byte_at(w, k);
        h   = {byte_at(w, k & 2), byte_at(w, (k & 2) + 1)};
        chk_noce = v && (op inside {LH, LHU, SH}) && k[0];
        if (v) begin
            case (op)
                LB:  res = {{24{b[7]}}, b};
                LBU: res = {24'h0, b};
                LH:  res = k[0] ? 32'h0 : {{16{h[15]}}, h};
                LHU: res = k[0] ? 32'h0 : {16'h0, h};
                LW:  res = w;
                LWL: begin
                    for (int p = 0; p + k <= 3; p++) begin
                        res = with_byte(res, p, byte_at(w, p + k));
                    end
                end
                LWR: begin
                    for (int p = 3 - k; p <= 3; p++) begin
                        res = with_byte(res, p, byte_at(w, p - 3 + k));
                    end
                end
                SB:  shadow[idx] = with_byte(w, k, reg2[7:0]);
                SH: begin
                    if (!k[0]) begin
                        shadow[idx] = with_byte(with_byte(w, k, reg2[15:8]), k + 1, reg2[7:0]);
                    end
                end
                SW:  shadow[idx] = reg2;
                SWL: begin
                    for (int p = k; p <= 3; p++) begin
                        shadow[idx] = with_byte(shadow[idx], p, byte_at(reg2, p - k));
                    end
                end
                SWR: begin
                    for (int p = 0; p <= k; p++) begin
                        shadow[idx] = with_byte(shadow[idx], p, byte_at(reg2, p + 3 - k));
                    end
                end
                default: res = reg2;
            endcase
        end
        q_due.push_back(cyc + 3);
        q_valid.push_back(v);
        q_wreg.push_back(wreg_i);
        q_wd.push_back(wd_i);
        q_data.push_back(res);
    endtask

    task automatic drive_random(input int n);
        repeat (n) begin
            drive($urandom_range(7, 0) != 0, mem_op_e'($urandom_range(12, 0)),
                  $urandom, $urandom);
        end
    endtask

    always @(negedge clk) begin : check_wb
        int v;
        while (q_due.size() > 0 && q_due[0] == cyc) begin
            v = q_valid.pop_front();
            void'(q_due.pop_front());
            checks++;
            assert (wb_valid_o == v) else begin
                errors++;
                $display("Error: wb_valid_o got %h expected %h", wb_valid_o, v);
            end
            if (v) begin
                assert (wb_wreg_o == q_wreg[0]) else begin
                    errors++;
                    $display("Error: wb_wreg_o got %h expected %h", wb_wreg_o, q_wreg[0]);
                end
                assert (wb_wd_o == q_wd[0]) else begin
                    errors++;
                    $display("Error: wb_wd_o got %h expected %h", wb_wd_o, q_wd[0]);
                end
                assert (wb_wdata_o == q_data[0]) else begin
                    errors++;
                    $display("Error: wb_wdata_o got %h expected %h", wb_wdata_o, q_data[0]);
                end
            end
            void'(q_wreg.pop_front());
            void'(q_wd.pop_front());
            void'(q_data.pop_front());
        end
    end

    initial begin
        logic [ADDR_W-1:0] a;
        void'($urandom(32'ha6a6_189b));
        {valid_i, wreg_i, addr_i, reg2_i, wd_i} = '0;
        op_i = NONE;
        rst_n_i = 1'b0;
        chk_noce = 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[i]   = (i * 32'h9e37_79b9) ^ {i[7:0], 24'h5a_c3_17};
            i_ram.mem[i] = shadow[i];
        end
        repeat (3) @(posedge clk);
        #5 rst_n_i = 1'b1;

        repeat (4) begin
            drive(1'b0, NONE, '0, '0);
            assert (!mem_ce_o && !mem_we_o && !wb_valid_o) else begin
                errors++;
                $display("RAM or writeback active with no operation after reset");
            end
        end

        for (int i = 0; i < 16; i++) begin
            a = {$urandom_range(255, 0), 2'b00};
            drive(1'b1, SW, a, $urandom);
            drive(1'b1, LW, a, $urandom);
        end
        drive_random(N_RAND);

        for (int i = 0; i < 4; i++) begin
            a = {$urandom_range(255, 0), 2'b00};
            for (int k = 0; k < 4; k++) drive(1'b1, LB, a + k, $urandom);
            for (int k = 0; k < 4; k++) drive(1'b1, LBU, a + k, $urandom);
            for (int k = 0; k < 4; k += 2) drive(1'b1, LH, a + k, $urandom);
            for (int k = 0; k < 4; k += 2) drive(1'b1, LHU, a + k, $urandom);
            for (int k = 0; k < 4; k++) drive(1'b1, SB, a + k, $urandom);
            for (int k = 0; k < 4; k += 2) drive(1'b1, SH, a + k, $urandom);
            drive(1'b1, LW, a, $urandom);
        end
        drive_random(N_RAND);

        for (int i = 0; i < 4; i++) begin
            a = {$urandom_range(255, 0), 2'b00};
            for (int k = 0; k < 4; k++) drive(1'b1, LWL, a + k, $urandom);
            for (int k = 0; k < 4; k++) drive(1'b1, LWR, a + k, $urandom);
        end
        drive_random(N_RAND);

        for (int k = 0; k < 4; k++) begin
            a = {$urandom_range(255, 0), 2'b00};
            drive(1'b1, SWL, a + k, $urandom);
            drive(1'b1, LW, a, $urandom);
            drive(1'b1, SWR, a + k, $urandom);
            drive(1'b1, LW, a, $urandom);
        end
        drive_random(N_RAND);

        // odd offsets only
        a = {$urandom_range(255, 0), 2'b00};
        for (int k = 1; k < 4; k += 2) begin
            drive(1'b1, LH, a + k, $urandom);
            drive(1'b1, LHU, a + k, $urandom);
            drive(1'b1, SH, a + k, $urandom);
        end
        drive(1'b1, LW, a, $urandom);
        drive_random(N_RAND);

        repeat (5) drive(1'b0, NONE, '0, '0);
        for (int i = 0; i < 256; i++) begin
            checks++;
            assert (i_ram.mem[i] == shadow[i]) else begin
                errors++;
                $display("Error: mem[%0d] got %h expected %h", i, i_ram.mem[i], shadow[i]);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
mem_pkg.sv
mem_req_stage.sv
mem_load_align.sv
mem_stage.sv
tb_data_ram.sv
mem_stage_properties.sv
tb_mem_stage.sv
